/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP       = aluExecStageTb
FILELIST  = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+include
rtl/aluPkg.sv
rtl/shifter.sv
rtl/bitManipUnit.sv
rtl/carrylessMul.sv
rtl/alu.sv
rtl/opQueue.sv
rtl/aluExecStage.sv
sim/aluExecStageTb.sv

/* include/alu_defines.svh */
// Global sizing constants for the RV32 integer execute stage
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

`define ALU_XLEN 32            // Operand and result width, RV32 only

//////////////////////////////////////////////////
// Flow control
//////////////////////////////////////////////////

// Operation queue slots, also the issuer's credit count after reset
`define ALU_QUEUE_DEPTH 4

// Result slots in the consumer, starting value of the output credit counter
`define ALU_RES_CREDITS 2

`endif

/* rtl/alu.sv */
// Combinational RV32 ALU covering base integer ops and the Zba, Zbb, Zbc and Zbs extensions
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu (
  input  logic [`ALU_XLEN-1:0] a,
  input  logic [`ALU_XLEN-1:0] b,
  input  aluPkg::aluOpE        op,
  output logic [`ALU_XLEN-1:0] result
);
  localparam int Xlen = `ALU_XLEN;
  localparam int AmtW = $clog2(Xlen);

  logic [Xlen-1:0] mask;      // Zbs one-hot bit select
  logic [Xlen-1:0] condB;     // b or mask
  logic [Xlen-1:0] condInvB;  // Optionally inverted condB
  logic [Xlen-1:0] preA;      // a after Zba pre-shift
  logic [Xlen-1:0] sum;
  logic [Xlen-1:0] shiftY;
  logic [Xlen-1:0] coreY;
  logic [Xlen-1:0] bmY;
  logic [Xlen-1:0] clY;
  logic            carry;
  logic            invB;
  logic            isZbs;
  logic            lt;
  logic            ltu;
  aluPkg::resSrcE  resSrc;

  //////////////////////////////////////////////////
  // Operand conditioning
  //////////////////////////////////////////////////

  assign invB = op inside {aluPkg::opSub, aluPkg::opSlt, aluPkg::opSltu, aluPkg::opMin,
                           aluPkg::opMax, aluPkg::opMinu, aluPkg::opMaxu, aluPkg::opAndn,
                           aluPkg::opOrn, aluPkg::opXnor, aluPkg::opBclr};
  assign isZbs = op inside {aluPkg::opBset, aluPkg::opBclr, aluPkg::opBinv, aluPkg::opBext};

  assign mask     = {{(Xlen-1){1'b0}}, 1'b1} << b[AmtW-1:0];
  assign condB    = isZbs ? mask : b;
  assign condInvB = invB ? ~condB : condB;  // ~mask gives bclr its and-mask

  always_comb begin
    case (op)
      aluPkg::opSh1add: preA = {a[Xlen-2:0], 1'b0};
      aluPkg::opSh2add: preA = {a[Xlen-3:0], 2'b00};
      aluPkg::opSh3add: preA = {a[Xlen-4:0], 3'b000};
      default:          preA = a;
    endcase
  end

  // Single adder, subtract = add ~b plus one
  assign {carry, sum} = {1'b0, preA} + {1'b0, condInvB} + {{Xlen{1'b0}}, invB};

  // Signs differ -> a's sign decides, otherwise the difference sign
  assign lt  = (a[Xlen-1] != b[Xlen-1]) ? a[Xlen-1] : sum[Xlen-1];
  assign ltu = ~carry;  // No carry out of a + ~b + 1 means borrow

  shifter u_shifter (
    .a      (a),
    .amt    (b[AmtW-1:0]),
    .right  (op inside {aluPkg::opSrl, aluPkg::opSra, aluPkg::opRor}),
    .arith  (op == aluPkg::opSra),
    .rotate (op inside {aluPkg::opRol, aluPkg::opRor}),
    .y      (shiftY)
  );

  bitManipUnit u_bitManip (.a(a), .b(b), .op(op), .lt(lt), .ltu(ltu), .y(bmY));

  carrylessMul u_clmul (.a(a), .b(b), .op(op), .y(clY));

  always_comb begin
    case (op)
      aluPkg::opSll, aluPkg::opSrl, aluPkg::opSra,
      aluPkg::opRol, aluPkg::opRor:                  coreY = shiftY;
      aluPkg::opSlt:                                 coreY = {{(Xlen-1){1'b0}}, lt};
      aluPkg::opSltu:                                coreY = {{(Xlen-1){1'b0}}, ltu};
      aluPkg::opXor, aluPkg::opXnor, aluPkg::opBinv: coreY = a ^ condInvB;
      aluPkg::opOr, aluPkg::opOrn, aluPkg::opBset:   coreY = a | condInvB;
      aluPkg::opAnd, aluPkg::opAndn, aluPkg::opBclr: coreY = a & condInvB;
      aluPkg::opBext:                                coreY = {{(Xlen-1){1'b0}}, |(a & mask)};
      default:                                       coreY = sum;  // add, sub, shNadd
    endcase
  end

  //////////////////////////////////////////////////
  // Result source
  //////////////////////////////////////////////////

  always_comb begin
    if (op inside {[aluPkg::opClmul:aluPkg::opClmulr]}) begin
      resSrc = aluPkg::resCarryless;
    end else if (op inside {[aluPkg::opClz:aluPkg::opZexth]}) begin
      resSrc = aluPkg::resBitManip;
    end else begin
      resSrc = aluPkg::resCore;
    end
  end

  always_comb begin
    case (resSrc)
      aluPkg::resBitManip:  result = bmY;
      aluPkg::resCarryless: result = clY;
      default:              result = coreY;
    endcase
  end

  // Upstream decode must never hand over a code past the last defined op
  always_comb begin
    opDefinedA: assert ($isunknown(op) || op <= aluPkg::opClmulr)
      else $error("alu: undefined opcode %0d", op);
  end

endmodule

/* rtl/aluExecStage.sv */
// Execute stage top with operation queue, ALU, result register and output credit counter
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluExecStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 opValid,
  input  aluPkg::aluOpE        op,
  input  logic [`ALU_XLEN-1:0] opA,
  input  logic [`ALU_XLEN-1:0] opB,
  input  aluPkg::tagT          opTag,
  output logic                 issueCredit,
  output logic                 resValid,
  output logic [`ALU_XLEN-1:0] result,
  output aluPkg::tagT          resTag,
  input  logic                 resCredit     // Consumer freed one result slot
);
  localparam int Xlen    = `ALU_XLEN;
  localparam int Credits = `ALU_RES_CREDITS;
  localparam int CntW    = $clog2(Credits + 1);

  logic            headValid;
  aluPkg::aluOpE   headOp;
  logic [Xlen-1:0] headA;
  logic [Xlen-1:0] headB;
  aluPkg::tagT     headTag;
  logic [Xlen-1:0] aluY;
  logic            pop;
  logic [CntW-1:0] resCnt;  // Free result slots at the consumer

  opQueue u_opQueue (
    .clk         (clk),
    .rstN        (rstN),
    .push        (opValid),
    .pushOp      (op),
    .pushA       (opA),
    .pushB       (opB),
    .pushTag     (opTag),
    .pop         (pop),
    .headValid   (headValid),
    .headOp      (headOp),
    .headA       (headA),
    .headB       (headB),
    .headTag     (headTag),
    .issueCredit (issueCredit)
  );

  alu u_alu (.a(headA), .b(headB), .op(headOp), .result(aluY));

  //////////////////////////////////////////////////
  // Output credits and result slot
  //////////////////////////////////////////////////

  // A credit arriving this cycle can be spent at once
  assign pop = headValid && ((resCnt != '0) || resCredit);

  // Each pop becomes exactly one resValid, so the credit is spent at the pop
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resCnt   <= CntW'(Credits);
      resValid <= 1'b0;
    end else begin
      if (pop && !resCredit) begin
        resCnt <= resCnt - 1'b1;
      end else if (resCredit && !pop) begin
        resCnt <= resCnt + 1'b1;
      end
      resValid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      result <= aluY;
      resTag <= headTag;
    end
  end

  // Consumer must not return more credits than results it received
  creditOverA: assert property (@(posedge clk) disable iff (!rstN)
    (resCredit && !pop) |-> (resCnt < CntW'(Credits)))
    else $error("aluExecStage: output credit counter overflow");

  // Counter stays between zero and its start value, a wrap shows up as too large
  creditRangeA: assert property (@(posedge clk) disable iff (!rstN)
    resCnt <= CntW'(Credits))
    else $error("aluExecStage: output credit counter out of range");

endmodule

/* rtl/aluPkg.sv */
// Shared types of the execute stage: decoded opcode, result source select and result tag
package aluPkg;

  // Decoded operation, one code per supported instruction
  typedef enum logic [5:0] {
    opAdd, opSub, opSll, opSrl, opSra,  // Base RV32I
    opSlt, opSltu, opXor, opOr, opAnd,
    opSh1add, opSh2add, opSh3add,       // Zba
    opAndn, opOrn, opXnor,              // Zbb logic with inverted b
    opBset, opBclr, opBinv, opBext,     // Zbs
    opRol, opRor,                       // Zbb rotates, done in the shared shifter
    opClz, opCtz, opCpop,               // Zbb counts
    opMin, opMax, opMinu, opMaxu,       // Zbb compare-select
    opSextb, opSexth, opZexth,          // Zbb extends
    opClmul, opClmulh, opClmulr         // Zbc
  } aluOpE;

  // Which sub-unit feeds the final result mux
  typedef enum logic [1:0] {
    resCore      = 2'd0,  // Adder, shifter, logic, Zba, Zbs
    resBitManip  = 2'd1,  // Counts, min/max, extends
    resCarryless = 2'd2   // Carry-less multiply
  } resSrcE;

  // Travels with the op through queue and result register
  typedef logic [3:0] tagT;

endpackage

/* rtl/bitManipUnit.sv */
// Zbb count, min/max and sign/zero extension operations
`timescale 1ns/1ps
`include "alu_defines.svh"

module bitManipUnit (
  input  logic [`ALU_XLEN-1:0] a,
  input  logic [`ALU_XLEN-1:0] b,
  input  aluPkg::aluOpE        op,
  input  logic                 lt,    // Signed a < b from the ALU adder
  input  logic                 ltu,   // Unsigned a < b from the ALU adder
  output logic [`ALU_XLEN-1:0] y
);
  localparam int Xlen = `ALU_XLEN;
  localparam int CntW = $clog2(Xlen) + 1;  // Needs to hold Xlen itself for clz/ctz of zero

  logic [CntW-1:0] clzCnt;
  logic [CntW-1:0] ctzCnt;
  logic [CntW-1:0] popCnt;

  // Highest set bit wins, scan goes upward
  always_comb begin
    clzCnt = CntW'(Xlen);
    for (int i = 0; i < Xlen; i++) begin
      if (a[i]) clzCnt = CntW'(Xlen - 1 - i);
    end
  end

  // Lowest set bit wins, scan goes downward
  always_comb begin
    ctzCnt = CntW'(Xlen);
    for (int i = Xlen - 1; i >= 0; i--) begin
      if (a[i]) ctzCnt = CntW'(i);
    end
  end

  always_comb begin
    popCnt = '0;
    for (int i = 0; i < Xlen; i++) begin
      popCnt = popCnt + CntW'(a[i]);
    end
  end

  //////////////////////////////////////////////////
  // Output select
  //////////////////////////////////////////////////

  always_comb begin
    case (op)
      aluPkg::opClz:   y = {{(Xlen-CntW){1'b0}}, clzCnt};
      aluPkg::opCtz:   y = {{(Xlen-CntW){1'b0}}, ctzCnt};
      aluPkg::opCpop:  y = {{(Xlen-CntW){1'b0}}, popCnt};
      aluPkg::opMin:   y = lt  ? a : b;
      aluPkg::opMax:   y = lt  ? b : a;
      aluPkg::opMinu:  y = ltu ? a : b;
      aluPkg::opMaxu:  y = ltu ? b : a;
      aluPkg::opSextb: y = {{(Xlen-8){a[7]}}, a[7:0]};
      aluPkg::opSexth: y = {{(Xlen-16){a[15]}}, a[15:0]};
      aluPkg::opZexth: y = {{(Xlen-16){1'b0}}, a[15:0]};
      default:         y = '0;  // Not a bitManip op, result mux ignores it
    endcase
  end

endmodule

/* rtl/carrylessMul.sv */
// Zbc carry-less multiply producing the low, high and reversed result forms
`timescale 1ns/1ps
`include "alu_defines.svh"

module carrylessMul (
  input  logic [`ALU_XLEN-1:0] a,
  input  logic [`ALU_XLEN-1:0] b,
  input  aluPkg::aluOpE        op,
  output logic [`ALU_XLEN-1:0] y
);
  localparam int Xlen = `ALU_XLEN;

  logic [2*Xlen-1:0] prod;  // Full XOR-accumulated product

  // Each set bit of b adds a shifted copy of a, XOR instead of add
  always_comb begin
    prod = '0;
    for (int i = 0; i < Xlen; i++) begin
      if (b[i]) prod = prod ^ ({{Xlen{1'b0}}, a} << i);
    end
  end

  always_comb begin
    case (op)
      aluPkg::opClmulh: y = prod[2*Xlen-1:Xlen];
      // Reversed form, product window starting one bit below the high half
      aluPkg::opClmulr: y = prod[2*Xlen-2:Xlen-1];
      default:          y = prod[Xlen-1:0];  // clmul
    endcase
  end

endmodule

/* rtl/opQueue.sv */
// Circular operation FIFO that returns one issue credit per pop
`timescale 1ns/1ps
`include "alu_defines.svh"

module opQueue (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 push,
  input  aluPkg::aluOpE        pushOp,
  input  logic [`ALU_XLEN-1:0] pushA,
  input  logic [`ALU_XLEN-1:0] pushB,
  input  aluPkg::tagT          pushTag,
  input  logic                 pop,
  output logic                 headValid,
  output aluPkg::aluOpE        headOp,
  output logic [`ALU_XLEN-1:0] headA,
  output logic [`ALU_XLEN-1:0] headB,
  output aluPkg::tagT          headTag,
  output logic                 issueCredit   // One-cycle pulse per freed slot
);
  localparam int Xlen  = `ALU_XLEN;
  localparam int Depth = `ALU_QUEUE_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  aluPkg::aluOpE   opMem  [0:Depth-1];
  logic [Xlen-1:0] aMem   [0:Depth-1];
  logic [Xlen-1:0] bMem   [0:Depth-1];
  aluPkg::tagT     tagMem [0:Depth-1];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic            full;

  // Wraps at Depth, so non power-of-two depths also work
  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
    return (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full      = (count == CntW'(Depth));
  assign headValid = (count != '0);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      opMem[wrPtr]  <= pushOp;
      aMem[wrPtr]   <= pushA;
      bMem[wrPtr]   <= pushB;
      tagMem[wrPtr] <= pushTag;
    end
  end

  // Head read is combinational, a push is visible the cycle after its edge
  assign headOp  = opMem[rdPtr];
  assign headA   = aMem[rdPtr];
  assign headB   = bMem[rdPtr];
  assign headTag = tagMem[rdPtr];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      count       <= '0;
      issueCredit <= 1'b0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      issueCredit <= pop;  // Credit goes back once the slot is really free
    end
  end

  // Issuer has to stay within its credits
  noPushFullA: assert property (@(posedge clk) disable iff (!rstN) !(push && full))
    else $error("opQueue: push while full");

  noPopEmptyA: assert property (@(posedge clk) disable iff (!rstN) !(pop && !headValid))
    else $error("opQueue: pop while empty");

endmodule

/* rtl/shifter.sv */
// Shared shift and rotate unit built around a single right-shift array
`timescale 1ns/1ps
`include "alu_defines.svh"

module shifter (
  input  logic [`ALU_XLEN-1:0]         a,
  input  logic [$clog2(`ALU_XLEN)-1:0] amt,
  input  logic                         right,   // 0 = left shift or rol
  input  logic                         arith,   // Sign fill, only meaningful with right
  input  logic                         rotate,
  output logic [`ALU_XLEN-1:0]         y
);
  localparam int Xlen = `ALU_XLEN;

  logic [Xlen-1:0]   aRev;      // Operand bit-reversed for left shifts
  logic [Xlen-1:0]   src;       // Operand as seen by the right shifter
  logic [Xlen-1:0]   fill;      // Upper half of the extended source
  logic [2*Xlen-1:0] shifted;
  logic [Xlen-1:0]   shOut;
  logic [Xlen-1:0]   shOutRev;

  // Left shift = reverse, shift right, reverse back
  always_comb begin
    for (int i = 0; i < Xlen; i++) begin
      aRev[i]     = a[Xlen-1-i];
      shOutRev[i] = shOut[Xlen-1-i];
    end
  end

  assign src = right ? a : aRev;

  // Rotate doubles the operand so bits shifted out wrap back in at the top
  always_comb begin
    if (rotate) begin
      fill = src;
    end else begin
      fill = {Xlen{arith & right & src[Xlen-1]}};  // Sign bit for sra, zero otherwise
    end
  end

  assign shifted = {fill, src} >> amt;
  assign shOut   = shifted[Xlen-1:0];

  assign y = right ? shOut : shOutRev;

endmodule

/* sim/aluExecStageTb.sv */
// Table-driven testbench for the execute stage with credit-based issuer and random consumer
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluExecStageTb;

  localparam int Depth        = `ALU_QUEUE_DEPTH;
  localparam int ResCredits   = `ALU_RES_CREDITS;
  localparam int StallLimit   = 100;   // Cycles without a credit once the consumer runs
  localparam int DrainLimit   = 2000;

  typedef struct packed {
    aluPkg::aluOpE          op;
    logic [`ALU_XLEN-1:0]   a;
    logic [`ALU_XLEN-1:0]   b;
    logic [`ALU_XLEN-1:0]   expY;
  } vecT;

  logic                 clk;
  logic                 rstN;
  logic                 opValid;
  aluPkg::aluOpE        op;
  logic [`ALU_XLEN-1:0] opA;
  logic [`ALU_XLEN-1:0] opB;
  aluPkg::tagT          opTag;
  logic                 issueCredit;
  logic                 resValid;
  logic [`ALU_XLEN-1:0] result;
  aluPkg::tagT          resTag;
  logic                 resCredit;

  vecT         vecs[$];
  int          issuedCnt;
  int          resCount;
  bit          holdCredits;     // Consumer keeps its credits while set
  logic [31:0] lfsrState;

  aluExecStage DUT (
    .clk         (clk),
    .rstN        (rstN),
    .opValid     (opValid),
    .op          (op),
    .opA         (opA),
    .opB         (opB),
    .opTag       (opTag),
    .issueCredit (issueCredit),
    .resValid    (resValid),
    .result      (result),
    .resTag      (resTag),
    .resCredit   (resCredit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] stepLfsr(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One LFSR step per bit taken
  function automatic int randomBits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsrState[0]);
      lfsrState = stepLfsr(lfsrState);
    end
    return v;
  endfunction

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkResult(input string name, input logic [`ALU_XLEN-1:0] got,
                             input logic [`ALU_XLEN-1:0] exp);
    if (got !== exp) abortRun($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic checkTag(input string name, input aluPkg::tagT got, input aluPkg::tagT exp);
    if (got !== exp) abortRun($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) abortRun($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp) abortRun($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic addVec(input aluPkg::aluOpE o, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] y);
    vecs.push_back('{o, a, b, y});
  endtask

  //////////////////////////////////////////////////
  // Stimulus table, expected values per RISC-V spec
  //////////////////////////////////////////////////

  task automatic loadTable();
    addVec(aluPkg::opAdd,    32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);  // Signed wrap
    addVec(aluPkg::opSub,    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff);
    addVec(aluPkg::opSll,    32'h0000_0001, 32'h0000_001f, 32'h8000_0000);
    addVec(aluPkg::opSrl,    32'h8000_0000, 32'h0000_001f, 32'h0000_0001);
    addVec(aluPkg::opSra,    32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
    addVec(aluPkg::opSlt,    32'h8000_0000, 32'h0000_0001, 32'h0000_0001);
    addVec(aluPkg::opSltu,   32'h8000_0000, 32'h0000_0001, 32'h0000_0000);
    addVec(aluPkg::opSltu,   32'h0000_0001, 32'hffff_ffff, 32'h0000_0001);
    addVec(aluPkg::opXor,    32'hffff_ffff, 32'h0f0f_0f0f, 32'hf0f0_f0f0);
    addVec(aluPkg::opOr,     32'h8000_0000, 32'h0000_0001, 32'h8000_0001);
    addVec(aluPkg::opAnd,    32'hffff_ffff, 32'h1234_5678, 32'h1234_5678);
    addVec(aluPkg::opSh1add, 32'h0000_0003, 32'h0000_0010, 32'h0000_0016);
    addVec(aluPkg::opSh2add, 32'h8000_0001, 32'h0000_0001, 32'h0000_0005);  // Top bits drop
    addVec(aluPkg::opSh3add, 32'h0000_0010, 32'h0000_0100, 32'h0000_0180);
    addVec(aluPkg::opBset,   32'h0000_0000, 32'h0000_001f, 32'h8000_0000);
    addVec(aluPkg::opBset,   32'h8000_0000, 32'h0000_0000, 32'h8000_0001);
    addVec(aluPkg::opBclr,   32'hffff_ffff, 32'h0000_0000, 32'hffff_fffe);
    addVec(aluPkg::opBclr,   32'hffff_ffff, 32'h0000_001f, 32'h7fff_ffff);
    addVec(aluPkg::opBinv,   32'h8000_0000, 32'h0000_001f, 32'h0000_0000);
    addVec(aluPkg::opBinv,   32'h0000_0000, 32'h0000_0000, 32'h0000_0001);
    addVec(aluPkg::opBext,   32'h8000_0000, 32'h0000_001f, 32'h0000_0001);
    addVec(aluPkg::opBext,   32'h8000_0000, 32'h0000_0000, 32'h0000_0000);
    addVec(aluPkg::opAndn,   32'hff00_ff00, 32'h0f0f_0f0f, 32'hf000_f000);
    addVec(aluPkg::opOrn,    32'h0000_0000, 32'h0000_ffff, 32'hffff_0000);
    addVec(aluPkg::opXnor,   32'h1234_5678, 32'h1234_5678, 32'hffff_ffff);
    addVec(aluPkg::opRol,    32'h8000_0001, 32'h0000_0001, 32'h0000_0003);
    addVec(aluPkg::opRor,    32'h0000_0001, 32'h0000_0001, 32'h8000_0000);
    addVec(aluPkg::opClz,    32'h0000_0000, 32'h0000_0000, 32'h0000_0020);  // Zero input
    addVec(aluPkg::opCtz,    32'h0000_0000, 32'h0000_0000, 32'h0000_0020);
    addVec(aluPkg::opClz,    32'h0001_0000, 32'h0000_0000, 32'h0000_000f);
    addVec(aluPkg::opCtz,    32'h0001_0000, 32'h0000_0000, 32'h0000_0010);
    addVec(aluPkg::opCpop,   32'hf0f0_f0f1, 32'h0000_0000, 32'h0000_0011);
    addVec(aluPkg::opMin,    32'h8000_0000, 32'h0000_0001, 32'h8000_0000);
    addVec(aluPkg::opMax,    32'h8000_0000, 32'h0000_0001, 32'h0000_0001);
    addVec(aluPkg::opMinu,   32'h8000_0000, 32'h0000_0001, 32'h0000_0001);
    addVec(aluPkg::opMaxu,   32'hffff_ffff, 32'h0000_0001, 32'hffff_ffff);
    addVec(aluPkg::opSextb,  32'h0000_0080, 32'h0000_0000, 32'hffff_ff80);
    addVec(aluPkg::opSexth,  32'h0001_7fff, 32'h0000_0000, 32'h0000_7fff);
    addVec(aluPkg::opZexth,  32'hffff_8000, 32'h0000_0000, 32'h0000_8000);
    addVec(aluPkg::opClmul,  32'h0000_0003, 32'h0000_0003, 32'h0000_0005);
    addVec(aluPkg::opClmulh, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);  // Product bit 62
    addVec(aluPkg::opClmulr, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000);
  endtask

  //////////////////////////////////////////////////
  // Issuer and consumer
  //////////////////////////////////////////////////

  // Spends one credit per push, regains one per issueCredit pulse
  task automatic runIssuer();
    int credits;
    int stall;
    credits = Depth;
    stall   = 0;
    while (issuedCnt < vecs.size()) begin
      @(posedge clk);
      #1;
      if (issueCredit) credits++;
      if (credits > Depth) abortRun("issuer holds more credits than queue slots");
      if (credits > 0) begin
        opValid = 1'b1;
        op      = vecs[issuedCnt].op;
        opA     = vecs[issuedCnt].a;
        opB     = vecs[issuedCnt].b;
        opTag   = aluPkg::tagT'(issuedCnt);  // Table index as tag, wraps at 16
        credits--;
        issuedCnt++;
        stall = 0;
      end else begin
        opValid = 1'b0;
        if (!holdCredits) stall++;
        if (stall > StallLimit) abortRun("issuer got no credit back in time");
      end
    end
    @(posedge clk);
    #1;
    opValid = 1'b0;
  endtask

  // Checks each result and returns its credit after a random delay
  task automatic runConsumer();
    int owed;
    int delay;
    owed  = 0;
    delay = randomBits(2);
    forever begin
      @(posedge clk);
      #1;
      resCredit = 1'b0;
      if (resValid) begin
        if (resCount >= vecs.size()) abortRun("result arrived beyond the last issued op");
        checkTag($sformatf("resTag[%0d]", resCount), resTag, aluPkg::tagT'(resCount));
        checkResult($sformatf("result[%0d]", resCount), result, vecs[resCount].expY);
        resCount++;
        owed++;
      end
      if (!holdCredits && owed > 0) begin
        if (delay == 0) begin
          resCredit = 1'b1;
          owed--;
          delay = randomBits(2);  // 0 to 3 idle cycles before the next credit
        end else begin
          delay--;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int waitCycles;
    rstN        = 1'b0;
    opValid     = 1'b0;
    op          = aluPkg::opAdd;
    opA         = '0;
    opB         = '0;
    opTag       = '0;
    resCredit   = 1'b0;
    issuedCnt   = 0;
    resCount    = 0;
    holdCredits = 1'b1;      // Start with the consumer withholding credits
    lfsrState   = 32'hc9f6_aa82;
    loadTable();

    repeat (5) begin
      @(posedge clk);
      #1;
      checkFlag("resValid", resValid, 1'b0);
      checkFlag("issueCredit", issueCredit, 1'b0);
    end
    rstN = 1'b1;
    @(negedge clk);
    checkFlag("resValid", resValid, 1'b0);      // First cycle out of reset
    checkFlag("issueCredit", issueCredit, 1'b0);

    fork
      runIssuer();
      runConsumer();
    join_none

    // Back-pressure: two results go out, then the queue fills and issue stops
    waitCycles = 0;
    while (issuedCnt < ResCredits + Depth) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles > 50) abortRun("issue never reached the credit limit");
    end
    repeat (20) @(negedge clk);
    checkCount("issuedCnt", issuedCnt, ResCredits + Depth);
    checkCount("resCount", resCount, ResCredits);

    holdCredits = 1'b0;
    waitCycles  = 0;
    while (resCount < vecs.size()) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles > DrainLimit) abortRun("results did not drain in time");
    end
    repeat (10) @(negedge clk);  // A stray extra result trips the consumer check
    checkCount("issuedCnt", issuedCnt, vecs.size());

    $display("TEST PASS");
    $finish;
  end

endmodule
